/* list.f */
mem_pkg.sv
mem_bus_if.sv
block_memory.sv
bus_arbiter.sv
fetch_port.sv
data_port.sv
memory_subsystem.sv
memory_subsystem_assertions.sv
tb_memory_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_memory_subsystem
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= Test passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@output="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* tb_memory_subsystem.sv */
`default_nettype none

module tb_memory_subsystem
	import mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int block_bits = default_block_bits;
	localparam int address_bits = default_address_bits;
	localparam int delay_bits = default_delay_bits;
	localparam int block_count = 2 ** address_bits;
	// longest wait for an ack edge which is far above the worst arbitration delay
	localparam int wait_limit = 64;

	logic clock = 1'b0;
	logic reset;
	logic fetch_req;
	logic [address_bits-1:0] fetch_address;
	logic fetch_ack;
	logic [block_bits-1:0] fetch_data;
	logic data_req;
	data_op_t data_op;
	logic [address_bits-1:0] data_address;
	logic [block_bits-1:0] data_wdata;
	logic data_ack;
	logic [block_bits-1:0] data_rdata;
	logic [31:0] random_state = 32'd8861;

	memory_subsystem
	#(
		.block_bits(block_bits),
		.address_bits(address_bits),
		.delay_bits(delay_bits)
	)
	i_dut
	(
		.clock(clock),
		.reset(reset),
		.fetch_req(fetch_req),
		.fetch_address(fetch_address),
		.fetch_ack(fetch_ack),
		.fetch_data(fetch_data),
		.data_req(data_req),
		.data_op(data_op),
		.data_address(data_address),
		.data_wdata(data_wdata),
		.data_ack(data_ack),
		.data_rdata(data_rdata)
	);

	// the checker sees the top level ports, the arbiter state and the shared bus
	bind memory_subsystem memory_subsystem_assertions
	#(
		.block_bits(block_bits),
		.address_bits(address_bits)
	)
	i_checks
	(
		.clock(clock),
		.reset(reset),
		.fetch_req(fetch_req),
		.fetch_address(fetch_address),
		.fetch_ack(fetch_ack),
		.fetch_data(fetch_data),
		.data_req(data_req),
		.data_op(data_op),
		.data_address(data_address),
		.data_wdata(data_wdata),
		.data_ack(data_ack),
		.data_rdata(data_rdata),
		.arbiter_state(i_arbiter.state),
		.memory_ren(memory_bus.ren),
		.memory_wen(memory_bus.wen)
	);

	always #50 clock = ~clock;

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped after a failure");
	endtask

	// the first failed assertion ends the run
	always @(negedge clock)
	begin
		if (i_dut.i_checks.failure_count != 0)
			report_failure("an assertion on the memory subsystem failed");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] value);
		logic [31:0] x;
		x = value;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		random_state = xorshift(random_state);
		return random_state;
	endfunction

	function automatic logic [address_bits-1:0] random_address();
		logic [31:0] value;
		value = next_random();
		return value[address_bits-1:0];
	endfunction

	function automatic logic [block_bits-1:0] random_block();
		return {next_random(), next_random()};
	endfunction

	// outputs are looked at on the falling edge away from the DUT's updates
	task automatic wait_for_fetch_ack(input logic level);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (fetch_ack !== level && cycles < wait_limit);
		if (fetch_ack !== level)
			report_failure("fetch_ack did not reach the expected level in time");
	endtask

	task automatic wait_for_data_ack(input logic level);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (data_ack !== level && cycles < wait_limit);
		if (data_ack !== level)
			report_failure("data_ack did not reach the expected level in time");
	endtask

	// one full four-phase transfer on each port
	task automatic fetch_transfer(input logic [address_bits-1:0] address);
		@(posedge clock);
		fetch_req <= 1'b1;
		fetch_address <= address;
		wait_for_fetch_ack(1'b1);
		@(posedge clock);
		fetch_req <= 1'b0;
		wait_for_fetch_ack(1'b0);
	endtask

	task automatic data_transfer(input data_op_t op, input logic [address_bits-1:0] address,
		input logic [block_bits-1:0] wdata);
		@(posedge clock);
		data_req <= 1'b1;
		data_op <= op;
		data_address <= address;
		data_wdata <= wdata;
		wait_for_data_ack(1'b1);
		@(posedge clock);
		data_req <= 1'b0;
		wait_for_data_ack(1'b0);
	endtask

	initial
	begin
		logic [address_bits-1:0] address;
		logic [address_bits-1:0] other;
		logic [31:0] value;
		reset <= 1'b0;
		fetch_req <= 1'b0;
		fetch_address <= '0;
		data_req <= 1'b0;
		data_op <= op_read;
		data_address <= '0;
		data_wdata <= '0;
		repeat (3) @(posedge clock);
		reset <= 1'b1;
		// both acks have to stay low while nothing is requested
		repeat (4) @(posedge clock);

		// memory contents start undefined, so every block is written first
		for (int i = 0; i < block_count; i++)
			data_transfer(op_write, address_bits'(i), random_block());
		for (int i = 0; i < block_count; i++)
			data_transfer(op_read, random_address(), '0);

		// second fetch hits the buffer and the write must invalidate it for the third
		for (int i = 0; i < 4; i++)
		begin
			address = random_address();
			fetch_transfer(address);
			fetch_transfer(address);
			data_transfer(op_write, address, random_block());
			fetch_transfer(address);
		end

		// both ports start in the same cycle and contend for the memory
		// a data write never targets the block being fetched alongside it
		for (int i = 0; i < 24; i++)
		begin
			address = random_address();
			other = random_address();
			if (other == address)
				other = ~address;
			value = next_random();
			fork
				fetch_transfer(address);
				data_transfer(data_op_t'(value[0]), other, random_block());
			join
		end

		repeat (2) @(posedge clock);
		if (i_dut.i_checks.failure_count == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
			report_failure("assertions failed during the run");
	end

endmodule

`default_nettype wire

/* memory_subsystem_assertions.sv */
`default_nettype none

// protocol and data checker bound into memory_subsystem
// the shadow store mirrors every block written through the data port
module memory_subsystem_assertions
	import mem_pkg::*;
#(
	parameter int block_bits = default_block_bits,
	parameter int address_bits = default_address_bits
)
(
	input logic clock,
	input logic reset,
	input logic fetch_req,
	input logic [address_bits-1:0] fetch_address,
	input logic fetch_ack,
	input logic [block_bits-1:0] fetch_data,
	input logic data_req,
	input data_op_t data_op,
	input logic [address_bits-1:0] data_address,
	input logic [block_bits-1:0] data_wdata,
	input logic data_ack,
	input logic [block_bits-1:0] data_rdata,
	input arbiter_state_t arbiter_state,
	input logic memory_ren,
	input logic memory_wen
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int block_count = 2 ** address_bits;

	// expected contents of each block, valid only where its written flag is set
	logic [block_bits-1:0] shadow [block_count];
	logic [block_count-1:0] written;
	logic data_ack_q;
	logic data_ack_rose;
	// number of failed assertions so far
	int failure_count = 0;

	assign data_ack_rose = data_ack && !data_ack_q;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			data_ack_q <= 1'b0;
			written <= '0;
		end
		else
		begin
			data_ack_q <= data_ack;
			if (data_ack_rose && data_op == op_write)
				written[data_address] <= 1'b1;
		end
	end

	// a write is taken into the shadow once the data port has acked it
	always_ff @(posedge clock)
	begin
		if (data_ack_rose && data_op == op_write)
			shadow[data_address] <= data_wdata;
	end

	// an ack only rises in answer to a request that was already up
	fetch_ack_after_req: assert property (@(posedge clock) disable iff (!reset)
		$rose(fetch_ack) |-> $past(fetch_req))
	else
	begin
		failure_count++;
		$error("fetch_ack rose while fetch_req was low");
	end

	data_ack_after_req: assert property (@(posedge clock) disable iff (!reset)
		$rose(data_ack) |-> $past(data_req))
	else
	begin
		failure_count++;
		$error("data_ack rose while data_req was low");
	end

	// a high ack follows req one cycle later so it holds while req holds and then falls
	fetch_ack_follows_req: assert property (@(posedge clock) disable iff (!reset)
		fetch_ack |=> fetch_ack == $past(fetch_req))
	else
	begin
		failure_count++;
		$error("fetch_ack did not follow fetch_req in the four-phase handshake");
	end

	data_ack_follows_req: assert property (@(posedge clock) disable iff (!reset)
		data_ack |=> data_ack == $past(data_req))
	else
	begin
		failure_count++;
		$error("data_ack did not follow data_req in the four-phase handshake");
	end

	// a read of a written block returns what was last written there
	data_read_value: assert property (@(posedge clock) disable iff (!reset)
		$rose(data_ack) && data_op == op_read && written[data_address]
		|-> data_rdata == shadow[data_address])
	else
	begin
		failure_count++;
		$error("FAIL data_rdata %h expected %h", $sampled(data_rdata),
			$sampled(shadow[data_address]));
	end

	// the same holds for fetches even right after the buffered block was rewritten
	fetch_read_value: assert property (@(posedge clock) disable iff (!reset)
		$rose(fetch_ack) && written[fetch_address] |-> fetch_data == shadow[fetch_address])
	else
	begin
		failure_count++;
		$error("FAIL fetch_data %h expected %h", $sampled(fetch_data),
			$sampled(shadow[fetch_address]));
	end

	memory_single_request: assert property (@(posedge clock) disable iff (!reset)
		!(memory_ren && memory_wen))
	else
	begin
		failure_count++;
		$error("memory bus had ren and wen high together");
	end

	// the data port can only complete while the arbiter still grants it the memory
	data_ack_under_grant: assert property (@(posedge clock) disable iff (!reset)
		$rose(data_ack) |-> arbiter_state == arb_data)
	else
	begin
		failure_count++;
		$error("data_ack rose while the arbiter did not grant the data port");
	end

endmodule

`default_nettype wire

/* memory_subsystem.sv */
`default_nettype none

module memory_subsystem
	import mem_pkg::*;
#(
	parameter int block_bits = default_block_bits,
	parameter int address_bits = default_address_bits,
	parameter int delay_bits = default_delay_bits
)
(
	input logic clock,
	input logic reset,
	// instruction fetch handshake
	input logic fetch_req,
	input logic [address_bits-1:0] fetch_address,
	output logic fetch_ack,
	output logic [block_bits-1:0] fetch_data,
	// data handshake
	input logic data_req,
	input data_op_t data_op,
	input logic [address_bits-1:0] data_address,
	input logic [block_bits-1:0] data_wdata,
	output logic data_ack,
	output logic [block_bits-1:0] data_rdata
);

	// one bus per client and one shared bus to the memory
	mem_bus_if #(.block_bits(block_bits), .address_bits(address_bits)) fetch_bus ();
	mem_bus_if #(.block_bits(block_bits), .address_bits(address_bits)) data_bus ();
	mem_bus_if #(.block_bits(block_bits), .address_bits(address_bits)) memory_bus ();

	// the fetch port also watches the shared bus for writes to its buffered block
	fetch_port #(.block_bits(block_bits), .address_bits(address_bits)) i_fetch_port
	(
		.clock(clock),
		.reset(reset),
		.fetch_req(fetch_req),
		.fetch_address(fetch_address),
		.fetch_ack(fetch_ack),
		.fetch_data(fetch_data),
		.bus(fetch_bus.client),
		.snoop(memory_bus.monitor)
	);

	data_port #(.block_bits(block_bits), .address_bits(address_bits)) i_data_port
	(
		.clock(clock),
		.reset(reset),
		.data_req(data_req),
		.data_op(data_op),
		.data_address(data_address),
		.data_wdata(data_wdata),
		.data_ack(data_ack),
		.data_rdata(data_rdata),
		.bus(data_bus.client)
	);

	bus_arbiter #(.block_bits(block_bits), .address_bits(address_bits)) i_arbiter
	(
		.clock(clock),
		.reset(reset),
		.fetch_bus(fetch_bus.memory),
		.data_bus(data_bus.memory),
		.memory_bus(memory_bus.client)
	);

	block_memory
	#(
		.block_bits(block_bits),
		.address_bits(address_bits),
		.delay_bits(delay_bits)
	)
	i_memory
	(
		.clock(clock),
		.reset(reset),
		.bus(memory_bus.memory)
	);

endmodule

`default_nettype wire

/* data_port.sv */
`default_nettype none

module data_port
	import mem_pkg::*;
#(
	parameter int block_bits = default_block_bits,
	parameter int address_bits = default_address_bits
)
(
	input logic clock,
	input logic reset,
	input logic data_req,
	input data_op_t data_op,
	input logic [address_bits-1:0] data_address,
	input logic [block_bits-1:0] data_wdata,
	output logic data_ack,
	output logic [block_bits-1:0] data_rdata,
	mem_bus_if.client bus
);

	port_state_t state;
	// request copy taken when req is first seen in idle
	data_op_t op;
	logic [address_bits-1:0] address;
	logic [block_bits-1:0] wdata;
	logic complete;

	// a read ends on ready and a write on done
	assign complete = (op == op_read) ? bus.ready : bus.done;

	// request lines fall with the state change, which leaves the required gap
	assign bus.ren = (state == port_busy) && (op == op_read);
	assign bus.wen = (state == port_busy) && (op == op_write);
	assign bus.block_address = address;
	assign bus.din = wdata;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= port_idle;
			data_ack <= 1'b0;
		end
		else
		begin
			case (state)
				port_idle:
					if (data_req)
						state <= port_busy;
				port_busy:
					if (complete)
					begin
						data_ack <= 1'b1;
						state <= port_ack;
					end
				// ack is held until the requester lets go of req
				port_ack:
					if (!data_req)
					begin
						data_ack <= 1'b0;
						state <= port_idle;
					end
				default:
					state <= port_idle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == port_idle && data_req)
		begin
			op <= data_op;
			address <= data_address;
			wdata <= data_wdata;
		end
		// writes leave the last read result in place
		if (state == port_busy && op == op_read && bus.ready)
			data_rdata <= bus.dout;
	end

endmodule

`default_nettype wire

/* fetch_port.sv */
`default_nettype none

module fetch_port
	import mem_pkg::*;
#(
	parameter int block_bits = default_block_bits,
	parameter int address_bits = default_address_bits
)
(
	input logic clock,
	input logic reset,
	input logic fetch_req,
	input logic [address_bits-1:0] fetch_address,
	output logic fetch_ack,
	output logic [block_bits-1:0] fetch_data,
	mem_bus_if.client bus,
	mem_bus_if.monitor snoop
);

	port_state_t state;
	// one block buffer, its address doubles as the tag
	logic [address_bits-1:0] buffer_address;
	logic [block_bits-1:0] buffer_block;
	logic buffer_valid;
	logic buffer_hit;
	logic snoop_write;

	// a write finishing on the shared memory bus at the buffered block
	assign snoop_write = snoop.done && snoop.wen && (snoop.block_address == buffer_address);

	// a write landing in this very cycle turns a hit into a miss
	assign buffer_hit = buffer_valid && !snoop_write && (buffer_address == fetch_address);

	// the fetch port only reads
	assign bus.ren = (state == port_busy);
	assign bus.wen = 1'b0;
	assign bus.block_address = buffer_address;
	assign bus.din = {block_bits{1'b0}};

	// the returned block is always the buffer contents
	assign fetch_data = buffer_block;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= port_idle;
			fetch_ack <= 1'b0;
			buffer_valid <= 1'b0;
		end
		else
		begin
			case (state)
				port_idle:
					if (fetch_req)
					begin
						if (buffer_hit)
						begin
							fetch_ack <= 1'b1;
							state <= port_ack;
						end
						else
						begin
							buffer_valid <= 1'b0;
							state <= port_busy;
						end
					end
				port_busy:
					if (bus.ready)
					begin
						buffer_valid <= 1'b1;
						fetch_ack <= 1'b1;
						state <= port_ack;
					end
				port_ack:
					if (!fetch_req)
					begin
						fetch_ack <= 1'b0;
						state <= port_idle;
					end
				default:
					state <= port_idle;
			endcase
			if (snoop_write)
				buffer_valid <= 1'b0;
		end
	end

	// buffer address is taken on a miss and the block when the read returns
	always_ff @(posedge clock)
	begin
		if (state == port_idle && fetch_req && !buffer_hit)
			buffer_address <= fetch_address;
		if (state == port_busy && bus.ready)
			buffer_block <= bus.dout;
	end

endmodule

`default_nettype wire

/* bus_arbiter.sv */
`default_nettype none

module bus_arbiter
	import mem_pkg::*;
#(
	parameter int block_bits = default_block_bits,
	parameter int address_bits = default_address_bits
)
(
	input logic clock,
	input logic reset,
	mem_bus_if.memory fetch_bus,
	mem_bus_if.memory data_bus,
	mem_bus_if.client memory_bus
);

	arbiter_state_t state;
	arbiter_state_t grant;
	// set when the data client had the last grant
	logic last_data;
	logic fetch_active;
	logic data_active;

	assign fetch_active = fetch_bus.ren || fetch_bus.wen;
	assign data_active = data_bus.ren || data_bus.wen;

	// from idle the grant is decided in the same cycle, so no latency is added
	// a held grant covers the drop cycle, which keeps a gap on the memory bus
	always_comb
	begin
		grant = state;
		if (state == arb_idle)
		begin
			if (fetch_active && data_active)
				grant = last_data ? arb_fetch : arb_data;
			else if (fetch_active)
				grant = arb_fetch;
			else if (data_active)
				grant = arb_data;
		end
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= arb_idle;
			last_data <= 1'b0;
		end
		else
		begin
			case (state)
				arb_idle:
				begin
					state <= grant;
					if (grant != arb_idle)
						last_data <= (grant == arb_data);
				end
				// release once the owner has dropped its request lines
				arb_fetch:
					if (!fetch_active)
						state <= arb_idle;
				arb_data:
					if (!data_active)
						state <= arb_idle;
				default:
					state <= arb_idle;
			endcase
		end
	end

	// the granted client reaches the memory, the other one sees nothing
	always_comb
	begin
		memory_bus.ren = 1'b0;
		memory_bus.wen = 1'b0;
		memory_bus.block_address = {address_bits{1'b0}};
		memory_bus.din = {block_bits{1'b0}};
		fetch_bus.ready = 1'b0;
		fetch_bus.done = 1'b0;
		fetch_bus.dout = {block_bits{1'b0}};
		data_bus.ready = 1'b0;
		data_bus.done = 1'b0;
		data_bus.dout = {block_bits{1'b0}};
		case (grant)
			arb_fetch:
			begin
				memory_bus.ren = fetch_bus.ren;
				memory_bus.wen = fetch_bus.wen;
				memory_bus.block_address = fetch_bus.block_address;
				memory_bus.din = fetch_bus.din;
				fetch_bus.ready = memory_bus.ready;
				fetch_bus.done = memory_bus.done;
				fetch_bus.dout = memory_bus.dout;
			end
			arb_data:
			begin
				memory_bus.ren = data_bus.ren;
				memory_bus.wen = data_bus.wen;
				memory_bus.block_address = data_bus.block_address;
				memory_bus.din = data_bus.din;
				data_bus.ready = memory_bus.ready;
				data_bus.done = memory_bus.done;
				data_bus.dout = memory_bus.dout;
			end
			default:
			begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* block_memory.sv */
`default_nettype none

module block_memory
	import mem_pkg::*;
#(
	parameter int block_bits = default_block_bits,
	parameter int address_bits = default_address_bits,
	parameter int delay_bits = default_delay_bits
)
(
	input logic clock,
	input logic reset,
	mem_bus_if.memory bus
);

	localparam int block_count = 2 ** address_bits;

	// storage has no reset, its contents after reset are undefined
	logic [block_bits-1:0] blocks [block_count];

	logic [delay_bits-1:0] delay_count;
	logic delayed;
	logic single_request;
	logic read_complete;
	logic write_complete;
	logic [block_bits-1:0] write_block;
	logic write_captured;

	// the counter only runs while exactly one of ren or wen is high
	assign single_request = bus.ren ^ bus.wen;
	assign delayed = &delay_count;

	// once the counter saturates a held read stays complete,
	// so a new address under the same ren is answered without delay
	assign read_complete = delayed && bus.ren && !bus.wen;
	assign write_complete = delayed && bus.wen && !bus.ren;

	// read data is zero unless a read is completing
	assign bus.dout = read_complete ? blocks[bus.block_address] : {block_bits{1'b0}};

	// saturating delay counter, cleared whenever the request is not a clean single one
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			delay_count <= '0;
		else if (!single_request)
			delay_count <= '0;
		else if (!delayed)
			delay_count <= delay_count + 1'b1;
	end

	// ready and done rise one edge after the counter reaches all ones
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			bus.ready <= 1'b0;
			bus.done <= 1'b0;
		end
		else
		begin
			bus.ready <= read_complete;
			bus.done <= write_complete;
		end
	end

	// marks that din of the current write has already been taken
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			write_captured <= 1'b0;
		else
			write_captured <= bus.wen && !bus.ren;
	end

	// din is taken on the first write cycle and committed in the cycle done is set
	always_ff @(posedge clock)
	begin
		if (bus.wen && !bus.ren && !write_captured)
			write_block <= bus.din;
		if (write_complete)
			blocks[bus.block_address] <= write_block;
	end

endmodule

`default_nettype wire

/* mem_bus_if.sv */
`default_nettype none

// one request path to a slow block memory
// a client holds exactly one of ren or wen until ready or done comes back,
// then drops both for at least one cycle
interface mem_bus_if
	import mem_pkg::*;
#(
	parameter int block_bits = default_block_bits,
	parameter int address_bits = default_address_bits
);

	logic ren;
	logic wen;
	logic [address_bits-1:0] block_address;
	logic [block_bits-1:0] din;
	// dout only carries a block while ready is high
	logic [block_bits-1:0] dout;
	logic ready;
	logic done;

	modport client (output ren, wen, block_address, din, input dout, ready, done);

	modport memory (input ren, wen, block_address, din, output dout, ready, done);

	// passive view, used to snoop writes on the shared memory bus
	modport monitor (input ren, wen, block_address, din, dout, ready, done);

endinterface

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

	// default width of one memory block in bits
	// a block is the unit that moves on every bus transfer
	localparam int default_block_bits = 64;

	// default width of a block address, which gives sixteen blocks
	localparam int default_address_bits = 4;

	// default width of the memory delay counter
	// the memory answers 2 ** delay_bits cycles after a request starts
	localparam int default_delay_bits = 2;

	// operation requested at the data port
	typedef enum logic
	{
		op_read = 1'b0,
		op_write = 1'b1
	} data_op_t;

	// arbiter grant state, idle means no client owns the memory bus
	typedef enum logic [1:0]
	{
		arb_idle = 2'd0,
		arb_fetch = 2'd1,
		arb_data = 2'd2
	} arbiter_state_t;

	// client port state shared by the fetch port and the data port
	typedef enum logic [1:0]
	{
		port_idle = 2'd0,
		port_busy = 2'd1,
		port_ack = 2'd2
	} port_state_t;

endpackage

`default_nettype wire
